//--- design/apb_requester.sv
module apb_requester (
	input  logic                 rx_clk,
	input  logic                 reset,

	// Request from the frame decoder
	sccb_req_if.requester        req,

	// APB requester port
	output logic                 apb_psel,
	output logic                 apb_penable,
	output logic                 apb_pwrite,
	output sccb_pkg::apb_addr_t  apb_paddr,
	output sccb_pkg::apb_data_t  apb_pwdata,
	output sccb_pkg::apb_strb_t  apb_pstrb,
	input  logic                 apb_pready,
	input  logic                 apb_pslverr,
	input  sccb_pkg::apb_data_t  apb_prdata,

	// Completion record for the transmit side
	output logic                 cpl_valid,
	output logic                 cpl_has_data,
	output logic                 cpl_success,
	output sccb_pkg::apb_data_t  cpl_data,
	input  logic                 cpl_ready
);

	sccb_pkg::requester_state_t state;

	// Successful read, the only case that returns data
	logic read_ok;

	assign read_ok = !apb_pwrite && !apb_pslverr;

	// One transfer in flight, next request waits for the completion handoff
	assign req.req_ready = (state == sccb_pkg::APB_IDLE);
	assign apb_psel = (state == sccb_pkg::APB_SETUP) || (state == sccb_pkg::APB_ACCESS);
	assign apb_penable = (state == sccb_pkg::APB_ACCESS);
	assign cpl_valid = (state == sccb_pkg::APB_CPL_HOLD);

	////////////////////////////////////////////////////////////
	// Transfer sequencing

	always_ff @(posedge rx_clk) begin
		if (reset) begin
			state <= sccb_pkg::APB_IDLE;
		end else begin
			case (state)
				sccb_pkg::APB_IDLE: begin
					if (req.req_valid)
						state <= sccb_pkg::APB_SETUP;
				end

				// Setup phase is always exactly one cycle
				sccb_pkg::APB_SETUP: state <= sccb_pkg::APB_ACCESS;

				// Completer stretches the access phase until pready
				sccb_pkg::APB_ACCESS: begin
					if (apb_pready)
						state <= sccb_pkg::APB_CPL_HOLD;
				end

				sccb_pkg::APB_CPL_HOLD: begin
					if (cpl_ready)
						state <= sccb_pkg::APB_IDLE;
				end

				default: state <= sccb_pkg::APB_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Request latch and completion capture

	always_ff @(posedge rx_clk) begin
		// Bus fields stay put from setup through the end of access
		if (req.req_valid && req.req_ready) begin
			apb_pwrite <= req.req_write;
			apb_paddr <= req.req_addr;
			apb_pwdata <= req.req_wdata;
			apb_pstrb <= req.req_strb;
		end

		// Writes and failed reads send an empty completion
		if ((state == sccb_pkg::APB_ACCESS) && apb_pready) begin
			cpl_has_data <= read_ok;
			cpl_success <= !apb_pslverr;
			cpl_data <= read_ok ? apb_prdata : '0;
		end
	end

endmodule

//--- design/sccb_frame_decoder.sv
module sccb_frame_decoder (
	input  logic                 rx_clk,
	input  logic                 reset,

	// Link-layer receive words
	input  logic                 ll_link_up,
	input  logic                 ll_start,
	input  logic                 ll_valid,
	input  sccb_pkg::ll_word_t   ll_data,
	input  logic                 ll_commit,
	input  logic                 ll_drop,

	// Decoded APB request
	sccb_req_if.decoder          req,

	// Acknowledgements from incoming completion frames
	output logic                 ack_valid,
	output logic                 ack_error,
	output sccb_pkg::apb_data_t  ack_data,
	input  logic                 ack_ready
);

	sccb_pkg::decoder_state_t state;

	// Set once the header says this frame is a completion
	logic frame_is_ack;

	// Word split into its four frame bytes
	sccb_pkg::frame_byte_t ll_byte [4];

	// Continuation word is missing, dropped or the link went away
	logic cont_bad;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			ll_byte[i] = ll_data[8*i +: 8];
		end
	end

	assign cont_bad = ll_drop || !ll_valid || !ll_link_up;

	// Held request or acknowledgement is presented straight from the state
	assign req.req_valid = (state == sccb_pkg::DEC_REQ_HOLD);
	assign ack_valid = (state == sccb_pkg::DEC_ACK_HOLD);

	////////////////////////////////////////////////////////////
	// Frame state machine

	always_ff @(posedge rx_clk) begin
		if (reset) begin
			state <= sccb_pkg::DEC_IDLE;
			frame_is_ack <= 1'b0;
		end else begin
			case (state)

				// Wait for a start word and dispatch on its header byte
				sccb_pkg::DEC_IDLE: begin
					if (ll_link_up && ll_start) begin
						frame_is_ack <= (ll_byte[0] == sccb_pkg::FRAME_COMP_EMPTY) ||
							(ll_byte[0] == sccb_pkg::FRAME_COMP_DATA);
						case (ll_byte[0])
							sccb_pkg::FRAME_APB_WRITE: state <= sccb_pkg::DEC_WRITE_1;
							sccb_pkg::FRAME_APB_READ: state <= sccb_pkg::DEC_READ_1;
							sccb_pkg::FRAME_COMP_DATA: state <= sccb_pkg::DEC_COMP_1;
							// Single word frame, only the commit is left
							sccb_pkg::FRAME_COMP_EMPTY: state <= sccb_pkg::DEC_WAIT_COMMIT;
							// Unknown header, frame is ignored
							default: state <= sccb_pkg::DEC_IDLE;
						endcase
					end
				end

				// Address low half and write data high half
				sccb_pkg::DEC_WRITE_1: begin
					if (cont_bad)
						state <= sccb_pkg::DEC_IDLE;
					else
						state <= sccb_pkg::DEC_WRITE_2;
				end

				// Last words of each frame type
				sccb_pkg::DEC_WRITE_2,
				sccb_pkg::DEC_READ_1,
				sccb_pkg::DEC_COMP_1: begin
					if (cont_bad)
						state <= sccb_pkg::DEC_IDLE;
					else
						state <= sccb_pkg::DEC_WAIT_COMMIT;
				end

				// Link layer confirms the CRC or throws the frame away
				sccb_pkg::DEC_WAIT_COMMIT: begin
					if (ll_drop || !ll_link_up)
						state <= sccb_pkg::DEC_IDLE;
					else if (ll_commit)
						state <= frame_is_ack ? sccb_pkg::DEC_ACK_HOLD :
							sccb_pkg::DEC_REQ_HOLD;
				end

				// Link input is ignored while the output is not taken
				sccb_pkg::DEC_REQ_HOLD: begin
					if (req.req_ready)
						state <= sccb_pkg::DEC_IDLE;
				end

				sccb_pkg::DEC_ACK_HOLD: begin
					if (ack_ready)
						state <= sccb_pkg::DEC_IDLE;
				end

				default: state <= sccb_pkg::DEC_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Payload capture

	// Byte 1 of the header word is the sequence number, skipped
	always_ff @(posedge rx_clk) begin
		case (state)
			sccb_pkg::DEC_IDLE: begin
				if (ll_start) begin
					req.req_addr[31:16] <= {ll_byte[2], ll_byte[3]};
					req.req_write <= (ll_byte[0] == sccb_pkg::FRAME_APB_WRITE);
					if (ll_byte[0] == sccb_pkg::FRAME_APB_WRITE)
						req.req_strb <= sccb_pkg::STRB_ALL;
					else
						req.req_strb <= '0;

					// Empty completion carries only a success flag
					if (ll_byte[0] == sccb_pkg::FRAME_COMP_EMPTY) begin
						ack_data <= '0;
						ack_error <= !ll_byte[2][0];
					end else begin
						ack_data[31:16] <= {ll_byte[2], ll_byte[3]};
						ack_error <= 1'b0;
					end
				end
			end

			sccb_pkg::DEC_WRITE_1: begin
				req.req_addr[15:0] <= {ll_byte[0], ll_byte[1]};
				req.req_wdata[31:16] <= {ll_byte[2], ll_byte[3]};
			end

			// Upper two bytes of this word are padding
			sccb_pkg::DEC_WRITE_2: begin
				req.req_wdata[15:0] <= {ll_byte[0], ll_byte[1]};
			end

			// Reads have no data, keep the bus quiet
			sccb_pkg::DEC_READ_1: begin
				req.req_addr[15:0] <= {ll_byte[0], ll_byte[1]};
				req.req_wdata <= '0;
			end

			sccb_pkg::DEC_COMP_1: begin
				ack_data[15:0] <= {ll_byte[0], ll_byte[1]};
			end

			default: begin
			end
		endcase
	end

endmodule

//--- design/sccb_pkg.sv
package sccb_pkg;

	////////////////////////////////////////////////////////////
	// Widths

	// One link-layer word, byte 0 in bits 7:0 arrives first
	typedef logic [31:0] ll_word_t;

	// One byte of a frame as it sits inside a link-layer word
	typedef logic [7:0] frame_byte_t;

	// APB address, data and byte strobes
	typedef logic [31:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;
	typedef logic [3:0] apb_strb_t;

	////////////////////////////////////////////////////////////
	// Frame header codes, all K characters on the wire

	// K27.7
	localparam frame_byte_t FRAME_APB_WRITE = 8'hfb;
	// K28.0
	localparam frame_byte_t FRAME_APB_READ = 8'h1c;
	// K29.7
	localparam frame_byte_t FRAME_COMP_DATA = 8'hfd;
	// K23.7
	localparam frame_byte_t FRAME_COMP_EMPTY = 8'hf7;

	// Writes always cover the full word, reads carry no strobes
	localparam apb_strb_t STRB_ALL = 4'b1111;

	////////////////////////////////////////////////////////////
	// State machines

	// Frame decoder, prefixed since both enums share this scope
	typedef enum logic [2:0] {
		DEC_IDLE,
		DEC_WRITE_1,
		DEC_WRITE_2,
		DEC_READ_1,
		DEC_COMP_1,
		DEC_WAIT_COMMIT,
		DEC_REQ_HOLD,
		DEC_ACK_HOLD
	} decoder_state_t;

	// APB requester
	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS,
		APB_CPL_HOLD
	} requester_state_t;

endpackage

//--- design/sccb_req_if.sv
// One decoded APB request, frame decoder to requester
interface sccb_req_if;

	// Handshake
	logic req_valid;
	logic req_ready;

	// Payload, stable for as long as req_valid is high
	logic req_write;
	sccb_pkg::apb_addr_t req_addr;
	sccb_pkg::apb_data_t req_wdata;
	sccb_pkg::apb_strb_t req_strb;

	// Producer side, the frame decoder
	modport decoder (
		output req_valid,
		output req_write,
		output req_addr,
		output req_wdata,
		output req_strb,
		input  req_ready
	);

	// Consumer side, the APB requester
	modport requester (
		input  req_valid,
		input  req_write,
		input  req_addr,
		input  req_wdata,
		input  req_strb,
		output req_ready
	);

endinterface

//--- design/sccb_rx_bridge.sv
module sccb_rx_bridge (
	input  logic                 rx_clk,
	input  logic                 reset,

	////////////////////////////////////////////////////////////
	// Link-layer receive side

	input  logic                 ll_link_up,
	input  logic                 ll_start,
	input  logic                 ll_valid,
	input  sccb_pkg::ll_word_t   ll_data,
	input  logic                 ll_commit,
	input  logic                 ll_drop,

	////////////////////////////////////////////////////////////
	// APB requester, clocked by rx_clk

	output logic                 apb_psel,
	output logic                 apb_penable,
	output logic                 apb_pwrite,
	output sccb_pkg::apb_addr_t  apb_paddr,
	output sccb_pkg::apb_data_t  apb_pwdata,
	output sccb_pkg::apb_strb_t  apb_pstrb,
	input  logic                 apb_pready,
	input  logic                 apb_pslverr,
	input  sccb_pkg::apb_data_t  apb_prdata,

	////////////////////////////////////////////////////////////
	// Records handed to the transmit side

	// Completion of a local APB transfer
	output logic                 cpl_valid,
	output logic                 cpl_has_data,
	output logic                 cpl_success,
	output sccb_pkg::apb_data_t  cpl_data,
	input  logic                 cpl_ready,

	// Acknowledgement of a remote transfer
	output logic                 ack_valid,
	output logic                 ack_error,
	output sccb_pkg::apb_data_t  ack_data,
	input  logic                 ack_ready
);

	// Decoded request between the two stages
	sccb_req_if req_bus ();

	// Link words in, requests and acknowledgements out
	sccb_frame_decoder u_decoder (
		.rx_clk     (rx_clk),
		.reset      (reset),
		.ll_link_up (ll_link_up),
		.ll_start   (ll_start),
		.ll_valid   (ll_valid),
		.ll_data    (ll_data),
		.ll_commit  (ll_commit),
		.ll_drop    (ll_drop),
		.req        (req_bus.decoder),
		.ack_valid  (ack_valid),
		.ack_error  (ack_error),
		.ack_data   (ack_data),
		.ack_ready  (ack_ready)
	);

	// Runs each request on APB and reports how it ended
	apb_requester u_requester (
		.rx_clk       (rx_clk),
		.reset        (reset),
		.req          (req_bus.requester),
		.apb_psel     (apb_psel),
		.apb_penable  (apb_penable),
		.apb_pwrite   (apb_pwrite),
		.apb_paddr    (apb_paddr),
		.apb_pwdata   (apb_pwdata),
		.apb_pstrb    (apb_pstrb),
		.apb_pready   (apb_pready),
		.apb_pslverr  (apb_pslverr),
		.apb_prdata   (apb_prdata),
		.cpl_valid    (cpl_valid),
		.cpl_has_data (cpl_has_data),
		.cpl_success  (cpl_success),
		.cpl_data     (cpl_data),
		.cpl_ready    (cpl_ready)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the sccb_rx_bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sccb_rx_bridge.f --top-module sccb_rx_bridge_tb \
	-o sccb_rx_bridge_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sccb_rx_bridge_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- sccb_rx_bridge.f
+incdir+verification
design/sccb_pkg.sv
design/sccb_req_if.sv
design/sccb_frame_decoder.sv
design/apb_requester.sv
design/sccb_rx_bridge.sv
verification/sccb_rx_bridge_tb.sv

//--- verification/sccb_rx_bridge_tb_tasks.svh
////////////////////////////////////////////////////////////
// Frame building and link-layer driving

// Bytes 2 and 3 of the header word carry a 16-bit field high byte first
function automatic sccb_pkg::ll_word_t head_word(input sccb_pkg::frame_byte_t hdr,
		input logic [15:0] upper);
	// Byte 1 is the sequence number and may hold any value
	return {upper[7:0], upper[15:8], 8'h5a, hdr};
endfunction

// Two 16-bit fields with each high byte first
function automatic sccb_pkg::ll_word_t pair_word(input logic [15:0] first,
		input logic [15:0] second);
	return {second[7:0], second[15:8], first[7:0], first[15:8]};
endfunction

// Start word, continuation words, then one commit or drop cycle
task automatic send_frame(input sccb_pkg::ll_word_t w0, input sccb_pkg::ll_word_t w1,
		input sccb_pkg::ll_word_t w2, input int words, input int ending);
	for (int i = 0; i <= words; i++) begin
		@(posedge rx_clk);
		#1;
		ll_start = (i == 0);
		// Gap frames lose the valid strobe on their second word
		ll_valid = (i > 0) && (i < words) && !(ending == END_GAP && i == 1);
		ll_data = (i == 0) ? w0 : (i == 1) ? w1 : w2;
		ll_commit = (i == words) && (ending != END_DROP);
		ll_drop = (i == words) && (ending == END_DROP);
	end
	@(posedge rx_clk);
	#1;
	ll_commit = 1'b0;
	ll_drop = 1'b0;
endtask

// APB write frame of three words or read frame of two
task automatic send_request(input logic write, input sccb_pkg::apb_addr_t addr,
		input sccb_pkg::apb_data_t data, input int ending);
	if (write)
		send_frame(head_word(sccb_pkg::FRAME_APB_WRITE, addr[31:16]),
			pair_word(addr[15:0], data[31:16]), pair_word(data[15:0], 16'h0), 3, ending);
	else
		send_frame(head_word(sccb_pkg::FRAME_APB_READ, addr[31:16]),
			pair_word(addr[15:0], 16'h0), '0, 2, ending);
endtask

////////////////////////////////////////////////////////////
// Checks

task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
	if (got !== expected) begin
		$display("error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
		error_count++;
	end
endtask

// Waits a bounded time for a completion or acknowledgement
task automatic await_output(input logic want_ack, input string what);
	int waited;
	waited = 0;
	while (!(want_ack ? ack_valid : cpl_valid) && waited < 40) begin
		@(posedge rx_clk);
		#1;
		waited++;
	end
	if (!(want_ack ? ack_valid : cpl_valid)) begin
		$display("%s did not arrive within 40 cycles, at %0d ns", what, $time);
		error_count++;
	end
endtask

// Check the held completion, then take it
task automatic take_completion(input logic has_data, input logic success,
		input sccb_pkg::apb_data_t data);
	await_output(1'b0, "completion");
	check_value("cpl_has_data", 32'(cpl_has_data), 32'(has_data));
	check_value("cpl_success", 32'(cpl_success), 32'(success));
	check_value("cpl_data", cpl_data, data);
	cpl_ready = 1'b1;
	@(posedge rx_clk);
	#1;
	cpl_ready = 1'b0;
endtask

task automatic take_ack(input logic error, input sccb_pkg::apb_data_t data);
	await_output(1'b1, "acknowledgement");
	check_value("ack_error", 32'(ack_error), 32'(error));
	check_value("ack_data", ack_data, data);
	ack_ready = 1'b1;
	@(posedge rx_clk);
	#1;
	ack_ready = 1'b0;
endtask

// Last access the completer model saw
task automatic check_access(input int count, input logic write, input sccb_pkg::apb_addr_t addr);
	check_value("apb access count", apb_count, count);
	check_value("apb_pwrite", 32'(seen_write), 32'(write));
	check_value("apb_paddr", seen_addr, addr);
	check_value("apb_pstrb", 32'(seen_strb), write ? 32'(sccb_pkg::STRB_ALL) : 32'h0);
endtask

task automatic report_test(input string name, input int errors_before);
	tests_run++;
	if (error_count == errors_before) begin
		$display("test %s: pass", name);
	end else begin
		tests_failed++;
		$display("test %s: FAIL, %0d errors", name, error_count - errors_before);
	end
endtask

////////////////////////////////////////////////////////////
// Directed tests

task automatic test_write();
	int errors_before;
	int count_before;
	errors_before = error_count;
	count_before = apb_count;
	send_request(1'b1, 32'h4000_1234, 32'hdead_beef, END_COMMIT);
	take_completion(1'b0, 1'b1, '0);
	check_access(count_before + 1, 1'b1, 32'h4000_1234);
	check_value("apb_pwdata", seen_wdata, 32'hdead_beef);
	report_test("write", errors_before);
endtask

task automatic test_read();
	int errors_before;
	int count_before;
	errors_before = error_count;
	count_before = apb_count;
	read_value = 32'h1357_9bdf;
	send_request(1'b0, 32'h8000_00a8, '0, END_COMMIT);
	take_completion(1'b1, 1'b1, 32'h1357_9bdf);
	check_access(count_before + 1, 1'b0, 32'h8000_00a8);
	report_test("read", errors_before);
endtask

// Slave error hides the read data
task automatic test_read_error();
	int errors_before;
	int count_before;
	errors_before = error_count;
	count_before = apb_count;
	read_value = 32'h2468_ace0;
	slverr_value = 1'b1;
	send_request(1'b0, 32'h8000_0ff0, '0, END_COMMIT);
	take_completion(1'b0, 1'b0, '0);
	slverr_value = 1'b0;
	check_access(count_before + 1, 1'b0, 32'h8000_0ff0);
	report_test("read_error", errors_before);
endtask

// Dropped, gapped and unknown frames vanish and a good write follows
task automatic test_bad_frames();
	int errors_before;
	int count_before;
	int acks_before;
	errors_before = error_count;
	count_before = apb_count;
	acks_before = ack_cycles;
	send_request(1'b1, 32'h4000_0100, 32'h1111_2222, END_DROP);
	send_request(1'b1, 32'h4000_0104, 32'h3333_4444, END_GAP);
	send_frame(head_word(8'h3c, 16'h4000), pair_word(16'h0108, 16'h0), '0, 2, END_COMMIT);
	repeat (10) begin
		@(posedge rx_clk);
		#1;
	end
	check_value("apb access count", apb_count, count_before);
	check_value("acknowledgement cycles", ack_cycles, acks_before);
	check_value("cpl_valid", 32'(cpl_valid), 32'h0);
	send_request(1'b1, 32'h4000_010c, 32'h5555_6666, END_COMMIT);
	take_completion(1'b0, 1'b1, '0);
	check_access(count_before + 1, 1'b1, 32'h4000_010c);
	check_value("apb_pwdata", seen_wdata, 32'h5555_6666);
	report_test("bad_frames", errors_before);
endtask

// Success flag sits in bit 0 of byte 2
task automatic test_acks();
	int errors_before;
	int count_before;
	errors_before = error_count;
	count_before = apb_count;
	send_frame(head_word(sccb_pkg::FRAME_COMP_EMPTY, 16'h0100), '0, '0, 1, END_COMMIT);
	take_ack(1'b0, '0);
	send_frame(head_word(sccb_pkg::FRAME_COMP_EMPTY, 16'hfe00), '0, '0, 1, END_COMMIT);
	take_ack(1'b1, '0);
	send_frame(head_word(sccb_pkg::FRAME_COMP_DATA, 16'h89ab), pair_word(16'hcdef, 16'h0),
		'0, 2, END_COMMIT);
	take_ack(1'b0, 32'h89ab_cdef);
	check_value("apb access count", apb_count, count_before);
	report_test("acks", errors_before);
endtask

// Held completion blocks the next APB transfer
task automatic test_backpressure();
	int errors_before;
	int count_before;
	errors_before = error_count;
	read_value = 32'h0bad_f00d;
	send_request(1'b0, 32'h4000_0200, '0, END_COMMIT);
	await_output(1'b0, "completion");
	count_before = apb_count;
	send_request(1'b1, 32'h4000_0204, 32'hcafe_0123, END_COMMIT);
	repeat (20) begin
		@(posedge rx_clk);
		#1;
		check_value("held cpl_valid", 32'(cpl_valid), 32'h1);
		check_value("held cpl_has_data", 32'(cpl_has_data), 32'h1);
		check_value("held cpl_success", 32'(cpl_success), 32'h1);
		check_value("held cpl_data", cpl_data, 32'h0bad_f00d);
		check_value("apb_psel while held", 32'(apb_psel), 32'h0);
	end
	check_value("apb access count while held", apb_count, count_before);
	take_completion(1'b1, 1'b1, 32'h0bad_f00d);
	take_completion(1'b0, 1'b1, '0);
	check_access(count_before + 1, 1'b1, 32'h4000_0204);
	check_value("apb_pwdata", seen_wdata, 32'hcafe_0123);
	report_test("backpressure", errors_before);
endtask

//--- verification/sccb_rx_bridge_tb.sv
module sccb_rx_bridge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// Six tests of under 150 cycles each, plus reset and margin
	localparam int MAX_CYCLES = 2000;

	// How a driven frame ends
	localparam int END_COMMIT = 0;
	localparam int END_DROP = 1;
	localparam int END_GAP = 2;

	logic rx_clk = 1'b0;
	logic reset;
	logic ll_link_up, ll_start, ll_valid, ll_commit, ll_drop;
	sccb_pkg::ll_word_t ll_data;
	logic apb_psel, apb_penable, apb_pwrite, apb_pready, apb_pslverr;
	sccb_pkg::apb_addr_t apb_paddr;
	sccb_pkg::apb_data_t apb_pwdata, apb_prdata;
	sccb_pkg::apb_strb_t apb_pstrb;
	logic cpl_valid, cpl_has_data, cpl_success, cpl_ready;
	sccb_pkg::apb_data_t cpl_data;
	logic ack_valid, ack_error, ack_ready;
	sccb_pkg::apb_data_t ack_data;

	// What the completer model answers and what it last saw
	int seed = 32'h33c64953;
	sccb_pkg::apb_data_t read_value;
	logic slverr_value;
	int apb_count;
	logic seen_write;
	sccb_pkg::apb_addr_t seen_addr;
	sccb_pkg::apb_data_t seen_wdata;
	sccb_pkg::apb_strb_t seen_strb;

	// Bookkeeping
	int ack_cycles = 0;
	int cycle_count = 0;
	int error_count = 0;
	int tests_run = 0;
	int tests_failed = 0;

	sccb_rx_bridge u_dut (.*);

	always #50 rx_clk = ~rx_clk;

	`include "sccb_rx_bridge_tb_tasks.svh"

	////////////////////////////////////////////////////////////
	// APB completer with 0 to 3 random wait states

	initial begin : apb_completer
		int wait_states;
		apb_pready = 1'b0;
		apb_pslverr = 1'b0;
		apb_prdata = '0;
		apb_count = 0;
		forever begin
			@(posedge rx_clk);
			#1;
			// Access follows this setup phase on the next edge
			if (apb_psel && !apb_penable) begin
				apb_count++;
				seen_write = apb_pwrite;
				seen_addr = apb_paddr;
				seen_wdata = apb_pwdata;
				seen_strb = apb_pstrb;
				wait_states = $unsigned($random(seed)) % 4;
				repeat (wait_states + 1) begin
					@(posedge rx_clk);
					#1;
					// Access phase keeps psel and penable up until pready
					check_value("apb_psel in access", 32'(apb_psel), 32'h1);
					check_value("apb_penable in access", 32'(apb_penable), 32'h1);
				end
				apb_pready = 1'b1;
				apb_pslverr = slverr_value;
				apb_prdata = read_value;
				@(posedge rx_clk);
				#1;
				apb_pready = 1'b0;
				apb_pslverr = 1'b0;
				apb_prdata = '0;
				// Bus goes idle and the completion shows up right after pready
				check_value("apb_psel after pready", 32'(apb_psel), 32'h0);
				check_value("apb_penable after pready", 32'(apb_penable), 32'h0);
				check_value("cpl_valid after pready", 32'(cpl_valid), 32'h1);
			end
		end
	end

	// Counts acknowledgement cycles so bad frames can be shown to raise none
	always @(negedge rx_clk) begin
		if (ack_valid)
			ack_cycles++;
	end

	// Watchdog
	always @(posedge rx_clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run still going after %0d cycles", MAX_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		reset = 1'b1;
		ll_link_up = 1'b0;
		ll_start = 1'b0;
		ll_valid = 1'b0;
		ll_data = '0;
		ll_commit = 1'b0;
		ll_drop = 1'b0;
		cpl_ready = 1'b0;
		ack_ready = 1'b0;
		read_value = '0;
		slverr_value = 1'b0;
		repeat (10) @(posedge rx_clk);
		#1;
		reset = 1'b0;
		ll_link_up = 1'b1;

		test_write();
		test_read();
		test_read_error();
		test_bad_frames();
		test_acks();
		test_backpressure();

		$display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
